//--- Makefile
# Verilator build, run and lint for the dual-port memory subsystem
# run from the project root, the testbench opens tb/tdpram_cases.txt

VERILATOR ?= verilator
TB_TOP    ?= tdpram_sys_tb
RTL_TOP   ?= tdpram_sys
FILELIST  ?= tdpram_sys.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation completed successfully
RTL_SRCS  ?= source/tdpram_pkg.sv source/la_tdpram_impl.sv source/mem_port_ctrl.sv \
             source/write_collision_guard.sv source/tdpram_sys.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

//--- source/la_tdpram_impl.sv
/* generic two-port RAM, per-bit write mask, registered read-first outputs
   both ports run on clk_a and a bit written by both ports is left to the caller */
`timescale 1ns/10ps
`default_nettype none

module la_tdpram_impl
   import tdpram_pkg::*;
(
   input  wire   clk_a,      // single memory clock
   // port a
   input  wire   ce_a,       // port a access
   input  wire   we_a,       // port a write
   input  data_t wmask_a,    // bit write mask
   input  addr_t addr_a,     // word address
   input  data_t din_a,      // write data
   output data_t dout_a,     // registered read data
   // port b
   input  wire   ce_b,       // port b access
   input  wire   we_b,       // port b write
   input  data_t wmask_b,    // bit write mask
   input  addr_t addr_b,     // word address
   input  data_t din_b,      // write data
   output data_t dout_b      // registered read data
);

   data_t mem [mem_words];   // storage array, no reset

   logic wr_en_a;            // port a writes this edge
   logic wr_en_b;            // port b writes this edge

   assign wr_en_a = ce_a & we_a;
   assign wr_en_b = ce_b & we_b;

   // one write process for both ports
   // port b lands last, so a shared bit takes b unless b's mask leaves it out
   always_ff @(posedge clk_a) begin
      for (int i = 0; i < data_w; i++) begin
         if (wr_en_a && wmask_a[i]) begin
            mem[addr_a][i] <= din_a[i];     // a bit update
         end
         if (wr_en_b && wmask_b[i]) begin
            mem[addr_b][i] <= din_b[i];     // b bit update, last in order
         end
      end
   end

   // reads see the array before this edge's writes (read-first)
   always_ff @(posedge clk_a) begin
      if (ce_a) begin
         dout_a <= mem[addr_a];   // held until next access
      end
   end

   always_ff @(posedge clk_a) begin
      if (ce_b) begin
         dout_b <= mem[addr_b];   // held until next access
      end
   end

endmodule : la_tdpram_impl

`default_nettype wire

//--- source/mem_port_ctrl.sv
/* request port controller: byte enables to bit mask, RAM strobes, read response
   one instance per RAM port */
`timescale 1ns/10ps
`default_nettype none

module mem_port_ctrl
   import tdpram_pkg::*;
(
   input  wire   clk_a,
   input  wire   reset,      // sync, active high
   // request side
   input  wire   req,        // single-cycle request strobe
   input  wire   wr,         // 1 = write, 0 = read
   input  be_t   be,         // byte enables for writes
   input  addr_t addr,       // word address
   input  data_t wdata,      // write data
   // RAM side
   output logic  ce,         // RAM access
   output logic  we,         // RAM write
   output data_t wmask,      // per-bit write mask
   output addr_t ram_addr,   // RAM address
   output data_t din,        // RAM write data
   input  data_t dout,       // RAM read data, one cycle after ce
   // response side
   output logic  rsp,        // read data valid
   output data_t rdata       // read data
);

   logic rd_pend;            // read accepted at last edge

   // strobes straight from the request, no buffering
   assign ce = req;
   assign we = req & wr;
   assign ram_addr = addr;
   assign din = wdata;

   // each byte enable fans out to its eight mask bits
   always_comb begin
      for (int i = 0; i < be_w; i++) begin
         wmask[8*i +: 8] = {8{be[i]}};
      end
   end

   // read pending marks the cycle the RAM output is valid
   always_ff @(posedge clk_a) begin
      if (reset) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= req & ~wr;   // reads only, writes get no rsp
      end
   end

   assign rsp = rd_pend;
   assign rdata = dout;          // RAM holds dout between reads

endmodule : mem_port_ctrl

`default_nettype wire

//--- source/tdpram_pkg.sv
/* shared widths and vector types for the dual-port memory subsystem
   imported by every RTL module and by the testbench */
`default_nettype none

package tdpram_pkg;

   // data path
   localparam int data_w = 32;                 // word width in bits
   localparam int be_w = data_w / 8;           // one enable per byte

   // address space
   localparam int addr_w = 8;                  // word address bits
   localparam int mem_words = 2 ** addr_w;     // 256 words of storage

   // write data, read data and per-bit masks all share this width
   typedef logic [data_w-1:0] data_t;

   typedef logic [addr_w-1:0] addr_t;          // word address

   typedef logic [be_w-1:0] be_t;              // byte enables, bit 0 = byte 0

endpackage : tdpram_pkg

`default_nettype wire

//--- source/tdpram_sys.sv
/* top level of the dual-port memory subsystem
   two request ports, write collision guard and the RAM, all on clk_a */
`timescale 1ns/10ps
`default_nettype none

module tdpram_sys
   import tdpram_pkg::*;
(
   input  wire   clk_a,
   input  wire   reset,        // sync, active high
   // port a
   input  wire   req_a,
   input  wire   wr_a,
   input  be_t   be_a,
   input  addr_t addr_a,
   input  data_t wdata_a,
   output logic  rsp_a,
   output data_t rdata_a,
   // port b
   input  wire   req_b,
   input  wire   wr_b,
   input  be_t   be_b,
   input  addr_t addr_b,
   input  data_t wdata_b,
   output logic  rsp_b,
   output data_t rdata_b,
   // status
   output logic  collision     // same-address dual write seen
);

   // controller a to RAM
   logic  ce_a, we_a;
   data_t wmask_a, din_a, dout_a;
   addr_t ram_addr_a;

   // controller b to guard and RAM
   logic  ce_b, we_b;
   data_t wmask_b_raw, wmask_b, din_b, dout_b;   // raw mask before the guard
   addr_t ram_addr_b;

   mem_port_ctrl port_a_ctrl (
      .clk_a(clk_a), .reset(reset),
      .req(req_a), .wr(wr_a), .be(be_a), .addr(addr_a), .wdata(wdata_a),
      .ce(ce_a), .we(we_a), .wmask(wmask_a), .ram_addr(ram_addr_a), .din(din_a),
      .dout(dout_a), .rsp(rsp_a), .rdata(rdata_a)
   );

   mem_port_ctrl port_b_ctrl (
      .clk_a(clk_a), .reset(reset),
      .req(req_b), .wr(wr_b), .be(be_b), .addr(addr_b), .wdata(wdata_b),
      .ce(ce_b), .we(we_b), .wmask(wmask_b_raw), .ram_addr(ram_addr_b), .din(din_b),
      .dout(dout_b), .rsp(rsp_b), .rdata(rdata_b)
   );

   write_collision_guard guard (
      .clk_a(clk_a), .reset(reset),
      .ce_a(ce_a), .we_a(we_a), .wmask_a(wmask_a), .addr_a(ram_addr_a),
      .ce_b(ce_b), .we_b(we_b), .wmask_b_in(wmask_b_raw), .addr_b(ram_addr_b),
      .wmask_b(wmask_b), .collision(collision)
   );

   la_tdpram_impl ram (
      .clk_a(clk_a),
      .ce_a(ce_a), .we_a(we_a), .wmask_a(wmask_a), .addr_a(ram_addr_a),
      .din_a(din_a), .dout_a(dout_a),
      .ce_b(ce_b), .we_b(we_b), .wmask_b(wmask_b), .addr_b(ram_addr_b),
      .din_b(din_b), .dout_b(dout_b)
   );

endmodule : tdpram_sys

`default_nettype wire

//--- source/write_collision_guard.sv
/* resolves same-address writes from both ports so port A wins bit by bit
   sits on the mask path between port B's controller and the RAM */
`timescale 1ns/10ps
`default_nettype none

module write_collision_guard
   import tdpram_pkg::*;
(
   input  wire   clk_a,
   input  wire   reset,          // sync, active high
   // port a request to RAM
   input  wire   ce_a,
   input  wire   we_a,
   input  data_t wmask_a,        // port a bit mask
   input  addr_t addr_a,
   // port b request to RAM
   input  wire   ce_b,
   input  wire   we_b,
   input  data_t wmask_b_in,     // port b mask from its controller
   input  addr_t addr_b,
   // outputs
   output data_t wmask_b,        // port b mask to RAM
   output logic  collision       // one-cycle pulse after a dual write
);

   logic same_wr;                // both ports write one address
   logic hit;                    // real collision, bytes on both sides

   assign same_wr = ce_a & we_a & ce_b & we_b & (addr_a == addr_b);
   assign hit = same_wr & (|wmask_a) & (|wmask_b_in);

   // drop b's bits wherever a writes them too
   assign wmask_b = same_wr ? (wmask_b_in & ~wmask_a) : wmask_b_in;

   // collision reported for the cycle after the edge
   always_ff @(posedge clk_a) begin
      if (reset) begin
         collision <= 1'b0;
      end else begin
         collision <= hit;
      end
   end

endmodule : write_collision_guard

`default_nettype wire

//--- tb/tdpram_cases.txt
# one line per clock, all hex: port a then port b
# req wr be addr wdata   req wr be addr wdata
1 1 f 10 11223344   0 0 0 00 00000000
1 0 0 10 00000000   1 1 f 20 aabbccdd
0 0 0 00 00000000   1 0 0 20 00000000
0 0 0 00 00000000   0 0 0 00 00000000
1 1 5 10 55667788   1 1 a 20 01020304
1 0 0 20 00000000   1 0 0 10 00000000
1 1 f 30 deadbeef   0 0 0 00 00000000
1 0 0 30 00000000   1 1 f 30 cafef00d
1 0 0 30 00000000   1 1 f 31 12345678
1 1 f 31 87654321   1 0 0 31 00000000
0 0 0 00 00000000   1 0 0 31 00000000
1 1 f 40 00000000   1 1 f 41 ffffffff
1 1 3 40 11111111   1 1 6 40 22222222
1 0 0 40 00000000   1 0 0 41 00000000
1 1 f 41 aaaaaaaa   1 1 f 41 55555555
1 1 0 42 99999999   1 1 f 42 33333333
1 0 0 41 00000000   1 0 0 42 00000000
0 0 0 00 00000000   0 0 0 00 00000000
1 0 0 10 00000000   1 0 0 20 00000000
1 0 0 20 00000000   1 0 0 30 00000000
1 0 0 30 00000000   1 0 0 31 00000000
1 0 0 40 00000000   1 0 0 41 00000000
1 0 0 42 00000000   1 0 0 40 00000000
0 0 0 00 00000000   0 0 0 00 00000000
1 1 c 10 ffff0000   0 0 0 00 00000000
1 0 0 10 00000000   1 0 0 10 00000000
0 0 0 00 00000000   0 0 0 00 00000000

//--- tb/tdpram_sys_assertions.sv
/* protocol assertions for the dual-port memory subsystem
   attached to tdpram_sys by bind from the testbench */
`timescale 1ns/10ps
`default_nettype none

module tdpram_sys_assertions
   import tdpram_pkg::*;
(
   input wire   clk_a,
   input wire   reset,
   input wire   req_a,
   input wire   wr_a,
   input be_t   be_a,
   input addr_t addr_a,
   input wire   req_b,
   input wire   wr_b,
   input be_t   be_b,
   input addr_t addr_b,
   input wire   rsp_a,
   input wire   rsp_b,
   input wire   collision
);

   int fail_count = 0;   // read back by the testbench

   logic dual_wr;        // real same-address dual write this cycle

   assign dual_wr = req_a & wr_a & req_b & wr_b & (addr_a == addr_b) & (|be_a) & (|be_b);

   // every read gets its response one cycle later
   rsp_a_after_read: assert property (@(posedge clk_a) disable iff (reset)
      (req_a && !wr_a) |=> rsp_a)
      else begin $error("port a read without response"); fail_count++; end

   rsp_b_after_read: assert property (@(posedge clk_a) disable iff (reset)
      (req_b && !wr_b) |=> rsp_b)
      else begin $error("port b read without response"); fail_count++; end

   // and no response shows up without a read
   rsp_a_needs_read: assert property (@(posedge clk_a) disable iff (reset)
      rsp_a |-> $past(req_a && !wr_a))
      else begin $error("port a response with no read"); fail_count++; end

   rsp_b_needs_read: assert property (@(posedge clk_a) disable iff (reset)
      rsp_b |-> $past(req_b && !wr_b))
      else begin $error("port b response with no read"); fail_count++; end

   coll_needs_dual_wr: assert property (@(posedge clk_a) disable iff (reset)
      collision |-> $past(dual_wr))
      else begin $error("collision without a dual write"); fail_count++; end

   quiet_after_reset: assert property (@(posedge clk_a)
      reset |=> (!rsp_a && !rsp_b && !collision))
      else begin $error("outputs active after reset"); fail_count++; end

endmodule : tdpram_sys_assertions

`default_nettype wire

//--- tb/tdpram_sys_tb.sv
/* testbench for the dual-port memory subsystem, replays tb/tdpram_cases.txt
   one line per clock and checks both ports against a reference memory */
`timescale 1ns/10ps
`default_nettype none

module tdpram_sys_tb
   import tdpram_pkg::*;
();

   localparam int clk_period = 20;                      // ns
   localparam int reset_cycles = 10;
   localparam int max_cases = 64;                       // case count limit
   localparam string cases_file = "tb/tdpram_cases.txt";

   logic  clk_a = 1'b0;
   logic  reset;
   logic  req_a, wr_a, req_b, wr_b;
   be_t   be_a, be_b;
   addr_t addr_a, addr_b;
   data_t wdata_a, wdata_b;
   logic  rsp_a, rsp_b, collision;
   data_t rdata_a, rdata_b;

   // stimulus table filled from the cases file
   logic  c_req_a [max_cases];
   logic  c_wr_a [max_cases];
   be_t   c_be_a [max_cases];
   addr_t c_addr_a [max_cases];
   data_t c_wdata_a [max_cases];
   logic  c_req_b [max_cases];
   logic  c_wr_b [max_cases];
   be_t   c_be_b [max_cases];
   addr_t c_addr_b [max_cases];
   data_t c_wdata_b [max_cases];
   int    n_cases = 0;

   data_t ref_mem [mem_words];   // reference copy of the RAM
   int    checks = 0;
   int    mismatches = 0;
   int    other_errors = 0;
   int    cycles = 0;
   int    cycle_limit = 0;       // 0 until the cases are loaded

   tdpram_sys tdpram_sys_inst (
      .clk_a(clk_a), .reset(reset),
      .req_a(req_a), .wr_a(wr_a), .be_a(be_a), .addr_a(addr_a), .wdata_a(wdata_a),
      .rsp_a(rsp_a), .rdata_a(rdata_a),
      .req_b(req_b), .wr_b(wr_b), .be_b(be_b), .addr_b(addr_b), .wdata_b(wdata_b),
      .rsp_b(rsp_b), .rdata_b(rdata_b),
      .collision(collision)
   );

   bind tdpram_sys tdpram_sys_assertions assertions_inst (
      .clk_a(clk_a), .reset(reset),
      .req_a(req_a), .wr_a(wr_a), .be_a(be_a), .addr_a(addr_a),
      .req_b(req_b), .wr_b(wr_b), .be_b(be_b), .addr_b(addr_b),
      .rsp_a(rsp_a), .rsp_b(rsp_b), .collision(collision)
   );

   always #(clk_period / 2) clk_a = ~clk_a;

   // run limit from the case count
   always @(posedge clk_a) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: run still going after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic load_cases;
      int fd;
      int rc;
      string line;
      logic [31:0] ra, wa, ba, aa, da, rb, wb, bb, ab, db;
      fd = $fopen(cases_file, "r");
      if (fd == 0) begin
         $display("could not open the cases file %s", cases_file);
         other_errors++;
      end else begin
         while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin   // skip notes
               rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                            ra, wa, ba, aa, da, rb, wb, bb, ab, db);
               if (rc == 10 && n_cases < max_cases) begin
                  c_req_a[n_cases] = ra[0];
                  c_wr_a[n_cases] = wa[0];
                  c_be_a[n_cases] = ba[be_w-1:0];
                  c_addr_a[n_cases] = aa[addr_w-1:0];
                  c_wdata_a[n_cases] = da;
                  c_req_b[n_cases] = rb[0];
                  c_wr_b[n_cases] = wb[0];
                  c_be_b[n_cases] = bb[be_w-1:0];
                  c_addr_b[n_cases] = ab[addr_w-1:0];
                  c_wdata_b[n_cases] = db;
                  n_cases++;
               end else if (rc == 10) begin
                  $display("too many cases, only the first %0d are used", max_cases);
                  other_errors++;
               end
            end
         end
         $fclose(fd);
      end
      if (n_cases == 0) begin
         $display("no cases were read, nothing to test");
         other_errors++;
      end
   endtask

   task automatic apply_case(input int i);
      req_a = c_req_a[i];
      wr_a = c_wr_a[i];
      be_a = c_be_a[i];
      addr_a = c_addr_a[i];
      wdata_a = c_wdata_a[i];
      req_b = c_req_b[i];
      wr_b = c_wr_b[i];
      be_b = c_be_b[i];
      addr_b = c_addr_b[i];
      wdata_b = c_wdata_b[i];
   endtask

   task automatic idle_inputs;
      req_a = 1'b0;
      wr_a = 1'b0;
      be_a = '0;
      addr_a = '0;
      wdata_a = '0;
      req_b = 1'b0;
      wr_b = 1'b0;
      be_b = '0;
      addr_b = '0;
      wdata_b = '0;
   endtask

   task automatic compare_value(input string what, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic verify_rsp(input string port, input logic got, input logic exp,
                             input data_t got_data, input data_t exp_data);
      if (got && !exp) begin
         $display("response on %s at %0t with no read pending", port, $time);
         other_errors++;
      end else if (!got && exp) begin
         $display("response on %s missing at %0t after a read", port, $time);
         other_errors++;
      end else if (got) begin
         compare_value({port, " rdata"}, got_data, exp_data);
      end
   endtask

   // inputs still held here are the ones sampled at the last edge
   task automatic score_cycle;
      logic  exp_rsp_a, exp_rsp_b, exp_coll, same_wr;
      data_t exp_rd_a, exp_rd_b;
      exp_rsp_a = !reset && req_a && !wr_a;
      exp_rsp_b = !reset && req_b && !wr_b;
      exp_rd_a = ref_mem[addr_a];                    // read-first, old word
      exp_rd_b = ref_mem[addr_b];
      same_wr = req_a && wr_a && req_b && wr_b && (addr_a == addr_b);
      exp_coll = !reset && same_wr && (|be_a) && (|be_b);
      verify_rsp("port a", rsp_a, exp_rsp_a, rdata_a, exp_rd_a);
      verify_rsp("port b", rsp_b, exp_rsp_b, rdata_b, exp_rd_b);
      compare_value("collision", data_t'(collision), data_t'(exp_coll));
      for (int i = 0; i < be_w; i++) begin
         if (req_b && wr_b && be_b[i]) ref_mem[addr_b][8*i +: 8] = wdata_b[8*i +: 8];
      end
      for (int i = 0; i < be_w; i++) begin   // port a last, wins overlaps
         if (req_a && wr_a && be_a[i]) ref_mem[addr_a][8*i +: 8] = wdata_a[8*i +: 8];
      end
   endtask

   initial begin
      reset = 1'b1;
      idle_inputs();
      load_cases();
      cycle_limit = n_cases + reset_cycles + 20;
      repeat (reset_cycles) @(posedge clk_a);
      @(negedge clk_a);
      score_cycle();                  // outputs quiet while in reset
      reset = 1'b0;
      for (int i = 0; i < n_cases; i++) begin
         @(negedge clk_a);
         score_cycle();
         apply_case(i);
      end
      idle_inputs();
      repeat (2) begin                // drain the last responses
         @(negedge clk_a);
         score_cycle();
      end
      other_errors += tdpram_sys_inst.assertions_inst.fail_count;
      $display("checks %0d, mismatches %0d, other errors %0d",
               checks, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule : tdpram_sys_tb

`default_nettype wire

//--- tdpram_sys.f
source/tdpram_pkg.sv
source/la_tdpram_impl.sv
source/mem_port_ctrl.sv
source/write_collision_guard.sv
source/tdpram_sys.sv
tb/tdpram_sys_assertions.sv
tb/tdpram_sys_tb.sv
